//--- project.f
scaler_pkg.sv
scaler_1d.sv
scaler_relay.sv
scaler_2d.sv
scaler_cfg.sv
scaler_top.sv
tb_clkgen.sv
tb_scaler_top.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_scaler_top -f project.f -o tb_scaler_top
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_scaler_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
fi
echo "pass message not found"
exit 1

//--- tb_scaler_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scaler_top;

	localparam int TB_W_WIDTH   = 10;
	localparam int TB_H_WIDTH   = 10;
	localparam int TB_BID_WIDTH = 2;
	localparam int L_BANKS      = 2 ** TB_BID_WIDTH;
	localparam int N_CASES      = 8;

	// ------------------------------------------------
	// case table
	// ------------------------------------------------
	// columns: source w/h, destination w/h, random ready, expect cfg error
	int tab_sw  [N_CASES] = '{ 8, 20, 5, 13, 0,  3,  8, 4};
	int tab_sh  [N_CASES] = '{ 6, 15, 4, 11, 4,  3,  6, 4};
	int tab_mw  [N_CASES] = '{16,  7, 5,  6, 4, 10, 16, 4};
	int tab_mh  [N_CASES] = '{ 9,  5, 4,  8, 4,  3,  9, 0};
	bit tab_rnd [N_CASES] = '{ 0,  1, 1,  0, 0,  1,  1, 0};
	bit tab_err [N_CASES] = '{ 0,  0, 0,  0, 1,  0,  0, 1};

	logic                    clk;
	logic                    resetn;
	logic                    start;
	logic [TB_W_WIDTH-1:0]   s_width;
	logic [TB_H_WIDTH-1:0]   s_height;
	logic [TB_W_WIDTH-1:0]   m_width;
	logic [TB_H_WIDTH-1:0]   m_height;
	logic                    ready;
	wire                     busy;
	wire                     cfg_err;
	wire                     valid;
	wire                     tuser;
	wire                     tlast;
	wire                     eof;
	wire [TB_H_WIDTH-1:0]    r_idx0;
	wire [TB_H_WIDTH-1:0]    r_idx1;
	wire [TB_BID_WIDTH-1:0]  r_bid0;
	wire [TB_BID_WIDTH-1:0]  r_bid1;
	wire                     r_update0;
	wire [TB_W_WIDTH-1:0]    c_idx0;
	wire [TB_W_WIDTH-1:0]    c_idx1;
	wire                     c_new1;

	int err_cnt;
	int beat_cnt;
	int cycle_cnt;
	int limit;
	int seed;

	tb_clkgen clkgen_i (
		.o_clk   (clk),
		.o_resetn(resetn)
	);

	scaler_top #(
		.P_W_WIDTH  (TB_W_WIDTH),
		.P_H_WIDTH  (TB_H_WIDTH),
		.P_BID_WIDTH(TB_BID_WIDTH)
	) scaler_top_i (
		.clk        (clk),
		.resetn     (resetn),
		.i_start    (start),
		.i_s_width  (s_width),
		.i_s_height (s_height),
		.i_m_width  (m_width),
		.i_m_height (m_height),
		.o_busy     (busy),
		.o_cfg_err  (cfg_err),
		.i_ready    (ready),
		.o_valid    (valid),
		.o_tuser    (tuser),
		.o_tlast    (tlast),
		.o_eof      (eof),
		.o_r_idx0   (r_idx0),
		.o_r_idx1   (r_idx1),
		.o_r_bid0   (r_bid0),
		.o_r_bid1   (r_bid1),
		.o_r_update0(r_update0),
		.o_c_idx0   (c_idx0),
		.o_c_idx1   (c_idx1),
		.o_c_new1   (c_new1)
	);

	// floor(k * s / m)
	function automatic int src_idx0(input int k, input int s, input int m);
		return (k * s) / m;
	endfunction

	function automatic int src_idx1(input int k, input int s, input int m);
		int i0;
		i0 = src_idx0(k, s, m);
		return (i0 + 1 > s - 1) ? s - 1 : i0 + 1;
	endfunction

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
		err_cnt++;
	endtask

	task automatic check_beat(input int c, input int n);
		int sw, sh, mw, mh, kc, kr;
		int e_c0, e_c1, e_r0, e_r1;
		logic e_upd, e_new;
		sw = tab_sw[c];
		sh = tab_sh[c];
		mw = tab_mw[c];
		mh = tab_mh[c];
		kc = n % mw;
		kr = n / mw;
		e_c0 = src_idx0(kc, sw, mw);
		e_c1 = src_idx1(kc, sw, mw);
		e_r0 = src_idx0(kr, sh, mh);
		e_r1 = src_idx1(kr, sh, mh);
		e_upd = (kc == 0) && (kr == 0 || e_r0 != src_idx0(kr - 1, sh, mh));
		e_new = (kc == 0) || (e_c1 != src_idx1(kc - 1, sw, mw));
		if (c_idx0 !== TB_W_WIDTH'(e_c0)) report_mismatch("o_c_idx0", c_idx0, e_c0);
		if (c_idx1 !== TB_W_WIDTH'(e_c1)) report_mismatch("o_c_idx1", c_idx1, e_c1);
		if (r_idx0 !== TB_H_WIDTH'(e_r0)) report_mismatch("o_r_idx0", r_idx0, e_r0);
		if (r_idx1 !== TB_H_WIDTH'(e_r1)) report_mismatch("o_r_idx1", r_idx1, e_r1);
		if (r_bid0 !== TB_BID_WIDTH'(e_r0 % L_BANKS))
			report_mismatch("o_r_bid0", r_bid0, e_r0 % L_BANKS);
		if (r_bid1 !== TB_BID_WIDTH'(e_r1 % L_BANKS))
			report_mismatch("o_r_bid1", r_bid1, e_r1 % L_BANKS);
		if (tuser !== (n == 0)) report_mismatch("o_tuser", tuser, n == 0);
		if (tlast !== (kc == mw - 1)) report_mismatch("o_tlast", tlast, kc == mw - 1);
		if (eof !== (n == mw * mh - 1)) report_mismatch("o_eof", eof, n == mw * mh - 1);
		if (r_update0 !== e_upd) report_mismatch("o_r_update0", r_update0, e_upd);
		if (c_new1 !== e_new) report_mismatch("o_c_new1", c_new1, e_new);
		beat_cnt++;
	endtask

	task automatic drive_sizes(input int sw, input int sh, input int mw, input int mh);
		s_width  = TB_W_WIDTH'(sw);
		s_height = TB_H_WIDTH'(sh);
		m_width  = TB_W_WIDTH'(mw);
		m_height = TB_H_WIDTH'(mh);
	endtask

	// ------------------------------------------------
	// one frame, with a stray start while busy
	// ------------------------------------------------
	task automatic run_frame(input int c);
		int total, n, cyc, rnd;
		total = tab_mw[c] * tab_mh[c];
		n     = 0;
		cyc   = 0;
		@(posedge clk);
		#1;
		drive_sizes(tab_sw[c], tab_sh[c], tab_mw[c], tab_mh[c]);
		start = 1'b1;
		while (n < total) begin
			@(negedge clk);
			if (cyc == 4 && !busy) begin
				$display("o_busy is low while case %0d is in progress", c);
				err_cnt++;
			end
			if (valid && ready) begin // transfers on the coming edge
				check_beat(c, n);
				n++;
			end
			@(posedge clk);
			#1;
			cyc++;
			start = (cyc == 4);
			if (cyc == 4) drive_sizes(3, 2, 2, 2); // must be ignored
			if (tab_rnd[c]) begin
				rnd   = $random(seed);
				ready = rnd[0];
			end else begin
				ready = 1'b1;
			end
		end
		@(negedge clk);
		if (busy) begin
			$display("o_busy still high after the last beat of case %0d", c);
			err_cnt++;
		end
		if (valid) begin
			$display("extra beat after the end of frame in case %0d", c);
			err_cnt++;
		end
		if (cfg_err !== 1'b0) report_mismatch("o_cfg_err", cfg_err, 0);
		ready = 1'b1;
	endtask

	task automatic run_bad_start(input int c);
		@(posedge clk);
		#1;
		drive_sizes(tab_sw[c], tab_sh[c], tab_mw[c], tab_mh[c]);
		start = 1'b1;
		ready = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		repeat (100) begin
			@(negedge clk);
			if (valid) begin
				$display("o_valid rose after a rejected start in case %0d", c);
				err_cnt++;
			end
			if (busy) begin
				$display("o_busy rose after a rejected start in case %0d", c);
				err_cnt++;
			end
			if (cfg_err !== 1'b1) report_mismatch("o_cfg_err", cfg_err, 1);
		end
	endtask

	// timeout
	initial begin
		cycle_cnt = 0;
		wait (limit > 0);
		while (cycle_cnt < limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the run did not complete", cycle_cnt);
		$display("cases %0d, beats checked %0d, errors %0d", N_CASES, beat_cnt, err_cnt);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int c;
		start = 1'b0;
		ready = 1'b1;
		drive_sizes(0, 0, 0, 0);
		err_cnt  = 0;
		beat_cnt = 0;
		seed     = 77340;
		limit    = 0;
		for (c = 0; c < N_CASES; c++) begin
			limit += 4 * tab_mw[c] * tab_mh[c] + 100 + 50;
		end
		wait (resetn);
		for (c = 0; c < N_CASES; c++) begin
			if (tab_err[c]) run_bad_start(c);
			else run_frame(c);
		end
		$display("cases %0d, beats checked %0d, errors %0d", N_CASES, beat_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int P_HALF_PERIOD  = 4, // 8 ns clock
	parameter int P_RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_resetn
);

	initial begin
		o_clk = 1'b0;
		forever #(P_HALF_PERIOD) o_clk = ~o_clk;
	end

	initial begin
		o_resetn = 1'b0;
		repeat (P_RESET_CYCLES) @(posedge o_clk);
		#1 o_resetn = 1'b1; // release just after the edge
	end

endmodule

`default_nettype wire

//--- scaler_top.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_top
	import scaler_pkg::*;
#(
	parameter int P_W_WIDTH   = DEF_W_WIDTH,
	parameter int P_H_WIDTH   = DEF_H_WIDTH,
	parameter int P_BID_WIDTH = DEF_BID_WIDTH
) (
	input  wire                   clk,
	input  wire                   resetn,

	input  wire                   i_start,
	input  wire [P_W_WIDTH-1:0]   i_s_width,
	input  wire [P_H_WIDTH-1:0]   i_s_height,
	input  wire [P_W_WIDTH-1:0]   i_m_width,
	input  wire [P_H_WIDTH-1:0]   i_m_height,
	output wire                   o_busy,
	output wire                   o_cfg_err,

	input  wire                   i_ready,
	output wire                   o_valid,
	output wire                   o_tuser,
	output wire                   o_tlast,
	output wire                   o_eof,
	output wire [P_H_WIDTH-1:0]   o_r_idx0,
	output wire [P_H_WIDTH-1:0]   o_r_idx1,
	output wire [P_BID_WIDTH-1:0] o_r_bid0,
	output wire [P_BID_WIDTH-1:0] o_r_bid1,
	output wire                   o_r_update0,
	output wire [P_W_WIDTH-1:0]   o_c_idx0,
	output wire [P_W_WIDTH-1:0]   o_c_idx1,
	output wire                   o_c_new1
);

	wire                 run;
	wire                 frame_done;
	wire [P_W_WIDTH-1:0] s_width;
	wire [P_H_WIDTH-1:0] s_height;
	wire [P_W_WIDTH-1:0] m_width;
	wire [P_H_WIDTH-1:0] m_height;
	wire [P_W_WIDTH-1:0] c_quot;
	wire [P_W_WIDTH-1:0] c_rem;
	wire [P_H_WIDTH-1:0] r_quot;
	wire [P_H_WIDTH-1:0] r_rem;

	scaler_cfg #(
		.P_W_WIDTH(P_W_WIDTH),
		.P_H_WIDTH(P_H_WIDTH)
	) scaler_cfg_i (
		.clk         (clk),
		.resetn      (resetn),
		.i_start     (i_start),
		.i_s_width   (i_s_width),
		.i_s_height  (i_s_height),
		.i_m_width   (i_m_width),
		.i_m_height  (i_m_height),
		.i_frame_done(frame_done),
		.o_busy      (o_busy),
		.o_cfg_err   (o_cfg_err),
		.o_run       (run),
		.o_s_width   (s_width),
		.o_s_height  (s_height),
		.o_m_width   (m_width),
		.o_m_height  (m_height),
		.o_c_quot    (c_quot),
		.o_c_rem     (c_rem),
		.o_r_quot    (r_quot),
		.o_r_rem     (r_rem)
	);

	scaler_2d #(
		.P_W_WIDTH  (P_W_WIDTH),
		.P_H_WIDTH  (P_H_WIDTH),
		.P_BID_WIDTH(P_BID_WIDTH)
	) scaler_2d_i (
		.clk         (clk),
		.resetn      (resetn),
		.i_run       (run),
		.i_s_width   (s_width),
		.i_s_height  (s_height),
		.i_m_width   (m_width),
		.i_m_height  (m_height),
		.i_c_quot    (c_quot),
		.i_c_rem     (c_rem),
		.i_r_quot    (r_quot),
		.i_r_rem     (r_rem),
		.i_ready     (i_ready),
		.o_valid     (o_valid),
		.o_tuser     (o_tuser),
		.o_tlast     (o_tlast),
		.o_eof       (o_eof),
		.o_r_idx0    (o_r_idx0),
		.o_r_idx1    (o_r_idx1),
		.o_r_bid0    (o_r_bid0),
		.o_r_bid1    (o_r_bid1),
		.o_r_update0 (o_r_update0),
		.o_c_idx0    (o_c_idx0),
		.o_c_idx1    (o_c_idx1),
		.o_c_new1    (o_c_new1),
		.o_frame_done(frame_done)
	);

endmodule

`default_nettype wire

//--- scaler_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_cfg
	import scaler_pkg::*;
#(
	parameter int P_W_WIDTH = DEF_W_WIDTH,
	parameter int P_H_WIDTH = DEF_H_WIDTH
) (
	input  wire                  clk,
	input  wire                  resetn,

	input  wire                  i_start,
	input  wire [P_W_WIDTH-1:0]  i_s_width,
	input  wire [P_H_WIDTH-1:0]  i_s_height,
	input  wire [P_W_WIDTH-1:0]  i_m_width,
	input  wire [P_H_WIDTH-1:0]  i_m_height,
	input  wire                  i_frame_done,

	output logic                 o_busy,
	output logic                 o_cfg_err,
	output logic                 o_run,
	output logic [P_W_WIDTH-1:0] o_s_width,
	output logic [P_H_WIDTH-1:0] o_s_height,
	output logic [P_W_WIDTH-1:0] o_m_width,
	output logic [P_H_WIDTH-1:0] o_m_height,
	output logic [P_W_WIDTH-1:0] o_c_quot,
	output logic [P_W_WIDTH-1:0] o_c_rem,
	output logic [P_H_WIDTH-1:0] o_r_quot,
	output logic [P_H_WIDTH-1:0] o_r_rem
);

	localparam int L_MAX_WIDTH = (P_W_WIDTH > P_H_WIDTH) ? P_W_WIDTH : P_H_WIDTH;
	localparam int L_CNT_WIDTH = $clog2(L_MAX_WIDTH + 1);

	typedef logic [P_W_WIDTH-1:0]   col_t;
	typedef logic [P_H_WIDTH-1:0]   row_t;
	typedef logic [L_CNT_WIDTH-1:0] cnt_t;

	cfg_state_e         state;
	cnt_t               bit_cnt;
	logic               start_ok;
	logic               size_zero;
	logic [P_W_WIDTH:0] c_trial; // partial remainder with next dividend bit
	logic [P_H_WIDTH:0] r_trial;
	logic               c_ge;
	logic               r_ge;

	assign start_ok  = i_start & (state == IDLE);
	assign size_zero = (i_s_width == '0) | (i_s_height == '0) |
		(i_m_width == '0) | (i_m_height == '0);

	assign o_busy = (state != IDLE);
	assign o_run  = (state == RUN);

	// quotient register doubles as the dividend shifter
	assign c_trial = {o_c_rem, o_c_quot[P_W_WIDTH-1]};
	assign r_trial = {o_r_rem, o_r_quot[P_H_WIDTH-1]};
	assign c_ge    = c_trial >= {1'b0, o_m_width};
	assign r_ge    = r_trial >= {1'b0, o_m_height};

	// ------------------------------------------------
	// control
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= IDLE;
			bit_cnt   <= '0;
			o_cfg_err <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				bit_cnt <= '0;
				if (start_ok) begin
					o_cfg_err <= size_zero;
					if (!size_zero) begin
						state <= DIV_COL;
					end
				end
			end
			DIV_COL: begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == cnt_t'(P_W_WIDTH - 1)) begin
					bit_cnt <= '0;
					state   <= DIV_ROW;
				end
			end
			DIV_ROW: begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == cnt_t'(P_H_WIDTH - 1)) begin
					bit_cnt <= '0;
					state   <= RUN;
				end
			end
			RUN: if (i_frame_done) state <= IDLE;
			default: state <= IDLE;
			endcase
		end
	end

	// ------------------------------------------------
	// sizes and restoring divider
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (start_ok) begin
			o_s_width  <= i_s_width;
			o_s_height <= i_s_height;
			o_m_width  <= i_m_width;
			o_m_height <= i_m_height;
			o_c_quot   <= i_s_width;
			o_c_rem    <= '0;
			o_r_quot   <= i_s_height;
			o_r_rem    <= '0;
		end else if (state == DIV_COL) begin
			o_c_quot <= {o_c_quot[P_W_WIDTH-2:0], c_ge};
			o_c_rem  <= c_ge ? col_t'(c_trial - {1'b0, o_m_width}) : c_trial[P_W_WIDTH-1:0];
		end else if (state == DIV_ROW) begin
			o_r_quot <= {o_r_quot[P_H_WIDTH-2:0], r_ge};
			o_r_rem  <= r_ge ? row_t'(r_trial - {1'b0, o_m_height}) : r_trial[P_H_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

//--- scaler_2d.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_2d
	import scaler_pkg::*;
#(
	parameter int P_W_WIDTH   = DEF_W_WIDTH,
	parameter int P_H_WIDTH   = DEF_H_WIDTH,
	parameter int P_BID_WIDTH = DEF_BID_WIDTH
) (
	input  wire                   clk,
	input  wire                   resetn,

	input  wire                   i_run,
	input  wire [P_W_WIDTH-1:0]   i_s_width,
	input  wire [P_H_WIDTH-1:0]   i_s_height,
	input  wire [P_W_WIDTH-1:0]   i_m_width,
	input  wire [P_H_WIDTH-1:0]   i_m_height,
	input  wire [P_W_WIDTH-1:0]   i_c_quot,
	input  wire [P_W_WIDTH-1:0]   i_c_rem,
	input  wire [P_H_WIDTH-1:0]   i_r_quot,
	input  wire [P_H_WIDTH-1:0]   i_r_rem,

	input  wire                   i_ready,
	output wire                   o_valid,
	output wire                   o_tuser,
	output wire                   o_tlast,
	output wire                   o_eof,
	output wire [P_H_WIDTH-1:0]   o_r_idx0,
	output wire [P_H_WIDTH-1:0]   o_r_idx1,
	output wire [P_BID_WIDTH-1:0] o_r_bid0,
	output wire [P_BID_WIDTH-1:0] o_r_bid1,
	output wire                   o_r_update0,
	output wire [P_W_WIDTH-1:0]   o_c_idx0,
	output wire [P_W_WIDTH-1:0]   o_c_idx1,
	output wire                   o_c_new1,
	output wire                   o_frame_done
);

	typedef logic [P_W_WIDTH-1:0]   col_t;
	typedef logic [P_H_WIDTH-1:0]   row_t;
	typedef logic [P_BID_WIDTH-1:0] bid_t;

	localparam int L_DATA_WIDTH = 5 + 2 * P_H_WIDTH + 2 * P_BID_WIDTH + 2 * P_W_WIDTH;

	logic                    algo_en;    // relay can take a beat
	logic                    beat_valid;
	logic                    col_step;
	logic                    row_step;
	logic                    gen_done;   // eof beat already handed to relay
	col_t                    c_idx0;
	col_t                    c_idx1;
	col_t                    prev_c_idx1;
	logic                    c_first;
	logic                    c_last;
	row_t                    r_idx0;
	row_t                    r_idx1;
	row_t                    prev_r_idx0;
	logic                    r_first;
	logic                    r_last;
	logic                    rc_update0;
	logic                    rc_new1;
	bid_t                    rc_bid0;
	bid_t                    rc_bid1;
	logic [L_DATA_WIDTH-1:0] s_data;
	logic [L_DATA_WIDTH-1:0] m_data;

	assign beat_valid = i_run & ~gen_done;
	assign col_step   = beat_valid & algo_en;
	assign row_step   = col_step & c_last;

	scaler_1d #(
		.P_WIDTH(P_W_WIDTH)
	) col_walker (
		.clk      (clk),
		.resetn   (resetn),
		.i_restart(~i_run),
		.i_step   (col_step),
		.i_s_nbr  (i_s_width),
		.i_m_nbr  (i_m_width),
		.i_quot   (i_c_quot),
		.i_rem    (i_c_rem),
		.o_idx0   (c_idx0),
		.o_idx1   (c_idx1),
		.o_first  (c_first),
		.o_last   (c_last)
	);

	scaler_1d #(
		.P_WIDTH(P_H_WIDTH)
	) row_walker (
		.clk      (clk),
		.resetn   (resetn),
		.i_restart(~i_run),
		.i_step   (row_step),
		.i_s_nbr  (i_s_height),
		.i_m_nbr  (i_m_height),
		.i_quot   (i_r_quot),
		.i_rem    (i_r_rem),
		.o_idx0   (r_idx0),
		.o_idx1   (r_idx1),
		.o_first  (r_first),
		.o_last   (r_last)
	);

	always_ff @(posedge clk) begin
		if (!resetn || !i_run) begin
			gen_done <= 1'b0;
		end else if (row_step && r_last) begin
			gen_done <= 1'b1;
		end
	end

	// history for the fetch flags
	always_ff @(posedge clk) begin
		if (col_step) begin
			prev_c_idx1 <= c_idx1;
		end
		if (row_step) begin
			prev_r_idx0 <= r_idx0;
		end
	end

	// ------------------------------------------------
	// beat
	// ------------------------------------------------
	assign rc_bid0    = r_idx0[P_BID_WIDTH-1:0];
	assign rc_bid1    = r_idx1[P_BID_WIDTH-1:0];
	assign rc_update0 = c_first & (r_first | (r_idx0 != prev_r_idx0));
	assign rc_new1    = c_first | (c_idx1 != prev_c_idx1);

	assign s_data = {
		r_first & c_first, c_last, r_last & c_last,
		r_idx0, r_idx1, rc_bid0, rc_bid1, rc_update0,
		c_idx0, c_idx1, rc_new1
	};

	scaler_relay #(
		.P_DATA_WIDTH(L_DATA_WIDTH)
	) relay (
		.clk      (clk),
		.resetn   (resetn),
		.i_s_valid(beat_valid),
		.i_s_data (s_data),
		.o_s_ready(algo_en),
		.o_m_valid(o_valid),
		.o_m_data (m_data),
		.i_m_ready(i_ready)
	);

	assign {
		o_tuser, o_tlast, o_eof,
		o_r_idx0, o_r_idx1, o_r_bid0, o_r_bid1, o_r_update0,
		o_c_idx0, o_c_idx1, o_c_new1
	} = m_data;

	assign o_frame_done = o_valid & i_ready & o_eof;

endmodule

`default_nettype wire

//--- scaler_relay.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_relay
	import scaler_pkg::*;
#(
	parameter int P_DATA_WIDTH = 2 * DEF_W_WIDTH
) (
	input  wire                     clk,
	input  wire                     resetn,

	input  wire                     i_s_valid,
	input  wire [P_DATA_WIDTH-1:0]  i_s_data,
	output logic                    o_s_ready,

	output logic                    o_m_valid,
	output logic [P_DATA_WIDTH-1:0] o_m_data,
	input  wire                     i_m_ready
);

	typedef logic [P_DATA_WIDTH-1:0] data_t;

	data_t skid_data;
	logic  skid_valid; // overflow entry in use
	logic  main_load;
	logic  s_fire;

	assign o_s_ready = ~skid_valid; // registered ready
	assign main_load = ~o_m_valid | i_m_ready;
	assign s_fire    = i_s_valid & o_s_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_m_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (main_load) begin
			o_m_valid  <= skid_valid | i_s_valid;
			skid_valid <= 1'b0;
		end else if (s_fire) begin
			skid_valid <= 1'b1; // main stalled, park the beat
		end
	end

	always_ff @(posedge clk) begin
		if (main_load) begin
			o_m_data <= skid_valid ? skid_data : i_s_data;
		end else if (s_fire) begin
			skid_data <= i_s_data;
		end
	end

endmodule

`default_nettype wire

//--- scaler_1d.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_1d
	import scaler_pkg::*;
#(
	parameter int P_WIDTH = DEF_W_WIDTH
) (
	input  wire               clk,
	input  wire               resetn,

	input  wire               i_restart,
	input  wire               i_step,

	input  wire [P_WIDTH-1:0] i_s_nbr,
	input  wire [P_WIDTH-1:0] i_m_nbr,
	input  wire [P_WIDTH-1:0] i_quot,
	input  wire [P_WIDTH-1:0] i_rem,

	output wire [P_WIDTH-1:0] o_idx0,
	output wire [P_WIDTH-1:0] o_idx1,
	output wire               o_first,
	output wire               o_last
);

	typedef logic [P_WIDTH-1:0] idx_t;
	typedef logic [P_WIDTH:0]   sum_t;

	idx_t m_cnt;    // destination index
	idx_t idx0;     // floor(m_cnt * s / m)
	idx_t acc;      // (m_cnt * s) mod m
	idx_t m_last;
	idx_t s_last;
	sum_t acc_sum;
	logic acc_wrap;

	assign m_last = i_m_nbr - 1'b1;
	assign s_last = i_s_nbr - 1'b1;

	// remainder can exceed 2**P_WIDTH before the wrap
	assign acc_sum  = {1'b0, acc} + {1'b0, i_rem};
	assign acc_wrap = acc_sum >= {1'b0, i_m_nbr};

	assign o_first = (m_cnt == '0);
	assign o_last  = (m_cnt == m_last);

	assign o_idx0 = idx0;
	assign o_idx1 = (idx0 == s_last) ? idx0 : idx0 + 1'b1; // clamp at edge

	// ------------------------------------------------
	// walker
	// ------------------------------------------------
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_cnt <= '0;
			idx0  <= '0;
			acc   <= '0;
		end else if (i_restart || (i_step && o_last)) begin
			m_cnt <= '0;
			idx0  <= '0;
			acc   <= '0;
		end else if (i_step) begin
			m_cnt <= m_cnt + 1'b1;
			if (acc_wrap) begin
				acc  <= idx_t'(acc_sum - {1'b0, i_m_nbr});
				idx0 <= idx0 + i_quot + 1'b1; // carry out of the remainder
			end else begin
				acc  <= acc_sum[P_WIDTH-1:0];
				idx0 <= idx0 + i_quot;
			end
		end
	end

endmodule

`default_nettype wire

//--- scaler_pkg.sv
`default_nettype none

package scaler_pkg;

	// ------------------------------------------------
	// default widths, overridden from the top level
	// ------------------------------------------------
	localparam int DEF_W_WIDTH   = 10; // source and destination widths
	localparam int DEF_H_WIDTH   = 10; // source and destination heights
	localparam int DEF_BID_WIDTH = 2;  // four line buffers

	// ------------------------------------------------
	// controller
	// ------------------------------------------------
	typedef enum logic [1:0] {
		IDLE,    // waiting for start
		DIV_COL, // dividing s_width by m_width
		DIV_ROW, // dividing s_height by m_height
		RUN      // walking the frame
	} cfg_state_e;

endpackage

`default_nettype wire
